// File: source/mdu_pkg.sv
package mdu_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0]   xlen_t;     // operand / result word
    typedef logic [XLEN/2-1:0] word_t;     // low half for W forms
    typedef logic [4:0]        reg_idx_t;  // destination register
    typedef logic [2:0]        md_op_t;    // funct3

    // funct3 encodings, top bit set selects the divider
    localparam md_op_t OP_MUL    = 3'd0;
    localparam md_op_t OP_MULH   = 3'd1;
    localparam md_op_t OP_MULHSU = 3'd2;
    localparam md_op_t OP_MULHU  = 3'd3;
    localparam md_op_t OP_DIV    = 3'd4;
    localparam md_op_t OP_DIVU   = 3'd5;
    localparam md_op_t OP_REM    = 3'd6;
    localparam md_op_t OP_REMU   = 3'd7;

endpackage

// File: source/div_unit.sv
module div_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              block,
    input  logic              in_valid,
    input  mdu_pkg::md_op_t   op,
    input  logic              is_w,
    input  mdu_pkg::xlen_t    src1,
    input  mdu_pkg::xlen_t    src2,
    input  mdu_pkg::reg_idx_t rd_in,
    input  logic              error_in,
    output logic              done,
    output mdu_pkg::xlen_t    res,
    output mdu_pkg::reg_idx_t res_rd,
    output logic              res_err
);
    import mdu_pkg::*;

    logic     valid_s1;
    md_op_t   op_s1;
    logic     is_w_s1;
    xlen_t    src1_s1;
    xlen_t    src2_s1;
    reg_idx_t rd_s1;
    logic     err_s1;

    logic     valid_s2;
    xlen_t    res_s2;
    reg_idx_t rd_s2;
    logic     err_s2;

    logic  zero64, zero32, div_zero;
    logic  ovf64, ovf32;
    xlen_t dvs64;
    word_t dvs32;
    xlen_t q_s64, r_s64, q_u64, r_u64;
    word_t q_s32, r_s32, q_u32, r_u32;
    word_t w_res;
    xlen_t res_d;

    always_ff @(posedge clk) begin
        if (!block) begin
            op_s1   <= op;
            is_w_s1 <= is_w;
            src1_s1 <= src1;
            src2_s1 <= src2;
            rd_s1   <= rd_in;
            err_s1  <= error_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (!block) begin
            valid_s1 <= in_valid && op[2];  // only divider codes
            valid_s2 <= valid_s1;
        end
    end

    assign zero64   = (src2_s1 == '0);
    assign zero32   = (src2_s1[31:0] == '0);
    assign div_zero = is_w_s1 ? zero32 : zero64;
    assign ovf64    = (src1_s1 == {1'b1, {(XLEN-1){1'b0}}}) && (src2_s1 == '1);
    assign ovf32    = (src1_s1[31:0] == 32'h8000_0000) && (src2_s1[31:0] == '1);

    // zero divisor becomes 1 since the result is overridden
    assign dvs64 = zero64 ? xlen_t'(1) : src2_s1;
    assign dvs32 = zero32 ? word_t'(1) : src2_s1[31:0];

    assign q_s64 = $signed(src1_s1) / $signed(dvs64);
    assign r_s64 = $signed(src1_s1) % $signed(dvs64);
    assign q_u64 = src1_s1 / dvs64;
    assign r_u64 = src1_s1 % dvs64;
    assign q_s32 = $signed(src1_s1[31:0]) / $signed(dvs32);
    assign r_s32 = $signed(src1_s1[31:0]) % $signed(dvs32);
    assign q_u32 = src1_s1[31:0] / dvs32;
    assign r_u32 = src1_s1[31:0] % dvs32;

    always_comb begin
        w_res = '0;
        res_d = '0;
        if (is_w_s1) begin
            case (op_s1)
                OP_DIV:  w_res = div_zero ? '1 : (ovf32 ? src1_s1[31:0] : q_s32);
                OP_DIVU: w_res = div_zero ? '1 : q_u32;
                OP_REM:  w_res = div_zero ? src1_s1[31:0] : (ovf32 ? '0 : r_s32);
                OP_REMU: w_res = div_zero ? src1_s1[31:0] : r_u32;
                default: w_res = '0;
            endcase
            res_d = {{32{w_res[31]}}, w_res};  // W results always sign extend
        end else begin
            case (op_s1)
                OP_DIV:  res_d = div_zero ? '1 : (ovf64 ? src1_s1 : q_s64);
                OP_DIVU: res_d = div_zero ? '1 : q_u64;
                OP_REM:  res_d = div_zero ? src1_s1 : (ovf64 ? '0 : r_s64);
                OP_REMU: res_d = div_zero ? src1_s1 : r_u64;
                default: res_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            res_s2 <= res_d;
            rd_s2  <= rd_s1;
            err_s2 <= err_s1 || div_zero;  // raise fault on /0
        end
    end

    assign done    = valid_s2;
    assign res     = res_s2;
    assign res_rd  = rd_s2;
    assign res_err = err_s2;

    a_res_known: assert property (@(posedge clk) disable iff (rst)
        done |-> !$isunknown(res));

endmodule

// File: source/mul_unit.sv
module mul_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              block,
    input  logic              in_valid,
    input  mdu_pkg::md_op_t   op,
    input  logic              is_w,
    input  mdu_pkg::xlen_t    src1,
    input  mdu_pkg::xlen_t    src2,
    input  mdu_pkg::reg_idx_t rd_in,
    input  logic              error_in,
    output logic              done,
    output mdu_pkg::xlen_t    res,
    output mdu_pkg::reg_idx_t res_rd,
    output logic              res_err
);
    import mdu_pkg::*;

    logic     valid_s1;
    md_op_t   op_s1;
    logic     is_w_s1;
    xlen_t    src1_s1;
    xlen_t    src2_s1;
    reg_idx_t rd_s1;
    logic     err_s1;

    logic     valid_s2;
    xlen_t    res_s2;
    reg_idx_t rd_s2;
    logic     err_s2;

    logic                     a_sgn, b_sgn;
    logic signed [2*XLEN+1:0] prod;
    word_t                    w_prod;
    xlen_t                    res_d;

    always_ff @(posedge clk) begin
        if (!block) begin
            op_s1   <= op;
            is_w_s1 <= is_w;
            src1_s1 <= src1;
            src2_s1 <= src2;
            rd_s1   <= rd_in;
            err_s1  <= error_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else if (!block) begin
            valid_s1 <= in_valid && !op[2];
            valid_s2 <= valid_s1;
        end
    end

    // one 65x65 signed multiplier covers all signedness combinations
    assign a_sgn  = (op_s1 == OP_MULH) || (op_s1 == OP_MULHSU);
    assign b_sgn  = (op_s1 == OP_MULH);
    assign prod   = $signed({a_sgn && src1_s1[XLEN-1], src1_s1})
                  * $signed({b_sgn && src2_s1[XLEN-1], src2_s1});
    assign w_prod = prod[31:0];  // low bits do not depend on sign

    always_comb begin
        case (op_s1)
            OP_MUL:    res_d = is_w_s1 ? {{32{w_prod[31]}}, w_prod} : prod[XLEN-1:0];
            OP_MULH,
            OP_MULHSU,
            OP_MULHU:  res_d = prod[2*XLEN-1:XLEN];
            default:   res_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            res_s2 <= res_d;
            rd_s2  <= rd_s1;
            err_s2 <= err_s1;
        end
    end

    assign done    = valid_s2;
    assign res     = res_s2;
    assign res_rd  = rd_s2;
    assign res_err = err_s2;

    a_w_only_mul: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !block && !op[2] && is_w) |-> (op == OP_MUL));

endmodule

// File: source/mdu_writeback.sv
module mdu_writeback (
    input  logic              clk,
    input  logic              rst,
    input  logic              div_done,
    input  mdu_pkg::xlen_t    div_res,
    input  mdu_pkg::reg_idx_t div_rd,
    input  logic              div_err,
    input  logic              mul_done,
    input  mdu_pkg::xlen_t    mul_res,
    input  mdu_pkg::reg_idx_t mul_rd,
    input  logic              mul_err,
    input  logic              out_ready,
    output logic              out_valid,
    output mdu_pkg::xlen_t    result,
    output mdu_pkg::reg_idx_t rd,
    output logic              error,
    output logic              block,
    output logic              in_ready
);

    // full output register that nobody takes freezes the stage
    assign block    = out_valid && !out_ready;
    assign in_ready = !block;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!block) begin
            out_valid <= div_done || mul_done;  // drops to 0 on a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            if (div_done) begin
                result <= div_res;
                rd     <= div_rd;
                error  <= div_err;
            end else if (mul_done) begin
                result <= mul_res;
                rd     <= mul_rd;
                error  <= mul_err;
            end
        end
    end

    // equal unit latency keeps issue order, so never two at once
    a_one_done: assert property (@(posedge clk) disable iff (rst)
        !(div_done && mul_done));

endmodule

// File: source/mdu_top.sv
module mdu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  mdu_pkg::md_op_t   op,
    input  logic              is_w,
    input  mdu_pkg::xlen_t    src1,
    input  mdu_pkg::xlen_t    src2,
    input  mdu_pkg::reg_idx_t rd_in,
    input  logic              error_in,
    output logic              out_valid,
    input  logic              out_ready,
    output mdu_pkg::xlen_t    result,
    output mdu_pkg::reg_idx_t rd,
    output logic              error
);
    import mdu_pkg::*;

    logic     block;
    logic     div_done, mul_done;
    xlen_t    div_res, mul_res;
    reg_idx_t div_rd, mul_rd;
    logic     div_err, mul_err;

    div_unit div0 (
        .clk      (clk),
        .rst      (rst),
        .block    (block),
        .in_valid (in_valid),
        .op       (op),
        .is_w     (is_w),
        .src1     (src1),
        .src2     (src2),
        .rd_in    (rd_in),
        .error_in (error_in),
        .done     (div_done),
        .res      (div_res),
        .res_rd   (div_rd),
        .res_err  (div_err)
    );

    mul_unit mul0 (
        .clk      (clk),
        .rst      (rst),
        .block    (block),
        .in_valid (in_valid),
        .op       (op),
        .is_w     (is_w),
        .src1     (src1),
        .src2     (src2),
        .rd_in    (rd_in),
        .error_in (error_in),
        .done     (mul_done),
        .res      (mul_res),
        .res_rd   (mul_rd),
        .res_err  (mul_err)
    );

    mdu_writeback wb0 (
        .clk       (clk),
        .rst       (rst),
        .div_done  (div_done),
        .div_res   (div_res),
        .div_rd    (div_rd),
        .div_err   (div_err),
        .mul_done  (mul_done),
        .mul_res   (mul_res),
        .mul_rd    (mul_rd),
        .mul_err   (mul_err),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .result    (result),
        .rd        (rd),
        .error     (error),
        .block     (block),
        .in_ready  (in_ready)
    );

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // period 4
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: testbench/mdu_tb.sv
module mdu_tb;
    import mdu_pkg::*;

    localparam int N_DIV64    = 48;
    localparam int N_DIVW     = 48;
    localparam int N_MUL      = 48;
    localparam int N_MIXED    = 160;
    localparam int N_DIRECTED = 48;  // upper bound of hand-picked ops
    localparam int N_TOTAL    = N_DIV64 + N_DIVW + N_MUL + N_MIXED + N_DIRECTED + 1;
    localparam xlen_t MIN64   = {1'b1, 63'b0};
    localparam xlen_t MAX64   = {1'b0, {63{1'b1}}};

    logic     clk, rst;
    logic     in_valid, in_ready;
    md_op_t   op;
    logic     is_w;
    xlen_t    src1, src2;
    reg_idx_t rd_in;
    logic     error_in;
    logic     out_valid, out_ready;
    xlen_t    result;
    reg_idx_t rd;
    logic     error;

    int seed = 37;
    int n_sent = 0;
    int cycle_cnt = 0;
    int accept_cycle = 0;
    logic rand_ready = 1'b0;

    xlen_t    exp_res_q[$];
    reg_idx_t exp_rd_q[$];
    logic     exp_err_q[$];

    logic     stalled = 1'b0;
    xlen_t    held_res;
    reg_idx_t held_rd;
    logic     held_err;

    tb_clock clk0 (.clk(clk), .rst(rst));

    mdu_top dut0 (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .is_w(is_w), .src1(src1), .src2(src2),
        .rd_in(rd_in), .error_in(error_in),
        .out_valid(out_valid), .out_ready(out_ready),
        .result(result), .rd(rd), .error(error)
    );

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_with($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // RISC-V division rules at 64 bits
    function automatic xlen_t div_rule64(md_op_t f, xlen_t a, xlen_t b);
        logic signed [63:0] sa, sb;
        logic               quot;
        sa = a;
        sb = b;
        quot = (f == OP_DIV) || (f == OP_DIVU);
        if (b == 0) return quot ? '1 : a;  // /0 gives all ones or the dividend
        if (f == OP_DIV || f == OP_REM) begin
            if (a == MIN64 && b == '1) return quot ? a : '0;  // overflow case
            return quot ? xlen_t'(sa / sb) : xlen_t'(sa % sb);
        end
        return quot ? a / b : a % b;
    endfunction

    // same rules on 32 bit halves
    function automatic word_t div_rule32(md_op_t f, word_t a, word_t b);
        logic signed [31:0] sa, sb;
        logic               quot;
        sa = a;
        sb = b;
        quot = (f == OP_DIV) || (f == OP_DIVU);
        if (b == 0) return quot ? '1 : a;
        if (f == OP_DIV || f == OP_REM) begin
            if (a == 32'h8000_0000 && b == '1) return quot ? a : '0;
            return quot ? word_t'(sa / sb) : word_t'(sa % sb);
        end
        return quot ? a / b : a % b;
    endfunction

    function automatic xlen_t ref_result(md_op_t f, logic w, xlen_t a, xlen_t b);
        logic [127:0] ea, eb, p;
        word_t        r32;
        ea = {64'b0, a};
        eb = {64'b0, b};
        if (f == OP_MULH || f == OP_MULHSU) ea = {{64{a[63]}}, a};
        if (f == OP_MULH) eb = {{64{b[63]}}, b};
        p = ea * eb;
        if (f[2]) begin
            if (!w) return div_rule64(f, a, b);
            r32 = div_rule32(f, a[31:0], b[31:0]);
            return {{32{r32[31]}}, r32};
        end
        if (f != OP_MUL) return p[127:64];  // high half of the product
        if (!w) return p[63:0];
        r32 = a[31:0] * b[31:0];
        return {{32{r32[31]}}, r32};
    endfunction

    function automatic logic ref_error(md_op_t f, logic w, xlen_t b, logic e);
        logic zero;
        zero = w ? (b[31:0] == 0) : (b == 0);  // W forms test the low word
        return e || (f[2] && zero);
    endfunction

    // called at posedge+1 and returns at posedge+1 after the transfer
    task automatic send_op(input md_op_t f, input logic w, input xlen_t a, input xlen_t b,
                           input logic e);
        in_valid = 1'b1;
        op       = f;
        is_w     = w;
        src1     = a;
        src2     = b;
        rd_in    = n_sent[4:0];
        error_in = e;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        exp_res_q.push_back(ref_result(f, w, a, b));
        exp_rd_q.push_back(n_sent[4:0]);
        exp_err_q.push_back(ref_error(f, w, b, e));
        accept_cycle = cycle_cnt;
        n_sent++;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (exp_res_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic rand_operand(output xlen_t v);
        int sel, hi, lo;
        sel = $random(seed);
        hi  = $random(seed);
        lo  = $random(seed);
        case (sel & 7)
            0: v = '0;
            1: v = {{60{hi[0]}}, lo[3:0]};  // small, either sign
            2: v = MIN64;
            3: v = '1;
            4: v = {{32{lo[31]}}, lo};
            5: v = {hi, 32'h0};  // upper half only
            default: v = {hi, lo};
        endcase
    endtask

    // kind 0 div64, 1 divw, 2 mul, 3 anything
    task automatic rand_send(input int kind, input logic with_err);
        int     r;
        md_op_t f;
        logic   w;
        xlen_t  a, b;
        r = $random(seed);
        case (kind)
            0, 1: f = {1'b1, r[1:0]};
            2: f = {1'b0, r[1:0]};
            default: f = r[2:0];
        endcase
        w = (kind == 1) || (kind != 0 && r[3] && (f[2] || f == OP_MUL));
        rand_operand(a);
        rand_operand(b);
        send_op(f, w, a, b, with_err && (r[7:4] == 0));
    endtask

    task automatic latency_test();
        int start;
        send_op(OP_MUL, 1'b0, 64'd6, 64'd7, 1'b0);
        start = accept_cycle;
        in_valid = 1'b0;
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        check("latency", 64'(cycle_cnt - start), 64'd3);  // three edges
    endtask

    task automatic special_cases();
        xlen_t a;
        a = 64'h1234_5678_9abc_def0;
        for (int k = 4; k < 8; k++) begin
            send_op(md_op_t'(k), 1'b0, a, 64'd0, 1'b0);
            send_op(md_op_t'(k), 1'b1, a, 64'hffff_ffff_0000_0000, 1'b0);
        end
        send_op(OP_DIVU, 1'b1, 64'hffff_ffff_8765_4321, 64'd0, 1'b0);
        send_op(OP_REM, 1'b1, 64'h0000_0000_8000_0001, 64'd0, 1'b0);
        send_op(OP_DIV, 1'b0, MIN64, '1, 1'b0);
        send_op(OP_REM, 1'b0, MIN64, '1, 1'b0);
        send_op(OP_DIV, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, 1'b0);
        send_op(OP_REM, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, 1'b0);
        send_op(OP_MUL, 1'b0, a, 64'd3, 1'b1);  // upstream error on the multiplier
        send_op(OP_MULHU, 1'b0, a, a, 1'b1);
        send_op(OP_DIV, 1'b0, a, 64'd7, 1'b1);
        send_op(OP_REMU, 1'b0, a, 64'd0, 1'b1);
    endtask

    task automatic mul_extremes();
        xlen_t pa [0:4];
        xlen_t pb [0:4];
        pa = '{MIN64, MIN64, '1, MAX64, MAX64};
        pb = '{MIN64, '1, '1, MAX64, MIN64};
        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < 4; k++) send_op(md_op_t'(k), 1'b0, pa[i], pb[i], 1'b0);
            send_op(OP_MUL, 1'b1, pa[i], pb[i], 1'b0);
        end
    endtask

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // random back-pressure
    always @(posedge clk) begin
        #1;
        if (rand_ready) out_ready = $random(seed) & 1;
        else out_ready = 1'b1;
    end

    // compare process samples mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled) begin
                check("out_valid", 64'(out_valid), 64'd1);  // must hold while stalled
                check("result", result, held_res);
                check("rd", 64'(rd), 64'(held_rd));
                check("error", 64'(error), 64'(held_err));
            end
            stalled  = out_valid && !out_ready;
            held_res = result;
            held_rd  = rd;
            held_err = error;
            if (out_valid && out_ready) begin
                if (exp_res_q.size() == 0) fail_with("output transfer with no operation pending");
                check("result", result, exp_res_q.pop_front());
                check("rd", 64'(rd), 64'(exp_rd_q.pop_front()));
                check("error", 64'(error), 64'(exp_err_q.pop_front()));
            end
        end
    end

    initial begin
        repeat (N_TOTAL * 20) @(posedge clk);
        fail_with($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
                            N_TOTAL * 20));
    end

    initial begin
        in_valid  = 1'b0;
        op        = OP_MUL;
        is_w      = 1'b0;
        src1      = '0;
        src2      = '0;
        rd_in     = '0;
        error_in  = 1'b0;
        out_ready = 1'b1;
        @(negedge rst);
        @(negedge clk);
        check("out_valid", 64'(out_valid), 64'd0);
        check("in_ready", 64'(in_ready), 64'd1);
        @(posedge clk);
        #1;

        latency_test();
        drain();
        for (int i = 0; i < N_DIV64; i++) rand_send(0, 1'b0);
        drain();
        for (int i = 0; i < N_DIVW; i++) rand_send(1, 1'b0);
        drain();
        special_cases();
        drain();
        mul_extremes();
        for (int i = 0; i < N_MUL; i++) rand_send(2, 1'b0);
        drain();

        rand_ready = 1'b1;
        for (int i = 0; i < N_MIXED; i++) rand_send(3, 1'b1);
        in_valid = 1'b0;
        rand_ready = 1'b0;
        drain();
        repeat (4) @(negedge clk);  // nothing extra may come out

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sources.f
source/mdu_pkg.sv
source/div_unit.sv
source/mul_unit.sv
source/mdu_writeback.sv
source/mdu_top.sv
testbench/tb_clock.sv
testbench/mdu_tb.sv

// File: Makefile
SRCS := $(wildcard source/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmdu_tb: $(SRCS) sources.f
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module mdu_tb -Mdir obj_dir

run: obj_dir/Vmdu_tb
	@out=$$(./obj_dir/Vmdu_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
